/* files.f */
hw/periph_pkg.sv
hw/mtimer.sv
hw/ext_irq_ctrl.sv
hw/intc.sv
hw/cfgreg.sv
hw/periph_subsys.sv
test/tb_periph_subsys.sv

/* Bender.yml */
package:
  name: periph_subsys

sources:
  # package first, then leaf blocks up to the top level
  - hw/periph_pkg.sv
  - hw/mtimer.sv
  - hw/ext_irq_ctrl.sv
  - hw/intc.sv
  - hw/cfgreg.sv
  - hw/periph_subsys.sv

  - target: test
    files:
      - test/tb_periph_subsys.sv

/* test/tb_periph_subsys.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_periph_subsys;

import periph_pkg::*;

localparam int CLK_PERIOD = 40;
localparam int DRIVE_DLY  = 5;
localparam int MAX_ROWS   = 48;

localparam logic [1:0] OP_IDLE  = 2'd0;
localparam logic [1:0] OP_WRITE = 2'd1;
localparam logic [1:0] OP_READ  = 2'd2;

localparam logic [31:0] CFG_BASE  = 32'h4000_0000;
localparam logic [31:0] INTC_BASE = 32'h4800_0000;

logic                   clk;
logic                   reset;
logic                   psel;
logic                   penable;
logic                   pwrite;
logic [ADDR_W-1:0]      paddr;
logic [STRB_W-1:0]      pstrb;
logic [DATA_W-1:0]      pwdata;
logic [DATA_W-1:0]      prdata;
logic                   pslverr;
logic                   pready;
logic [NUM_EXT_IRQ-1:0] ints;
logic                   msip;
logic                   mtip;
logic                   meip;
logic                   core_reset;

// one entry per row of stimulus and expected values
logic [1:0]             row_op    [MAX_ROWS];
logic [31:0]            row_addr  [MAX_ROWS];
logic [3:0]             row_strb  [MAX_ROWS];
logic [31:0]            row_data  [MAX_ROWS];
logic [7:0]             row_ints  [MAX_ROWS];
logic [31:0]            row_rdata [MAX_ROWS];
logic                   row_err   [MAX_ROWS];
logic [3:0]             row_side  [MAX_ROWS];

int                     n_rows;
int                     err_count;
int                     check_count;
logic                   table_ready;
logic [31:0]            lcg_state;
logic [31:0]            scratch_rnd;

periph_subsys periph_subsys_inst (
    .clk        ( clk        ),
    .reset      ( reset      ),
    .psel       ( psel       ),
    .penable    ( penable    ),
    .pwrite     ( pwrite     ),
    .paddr      ( paddr      ),
    .pstrb      ( pstrb      ),
    .pwdata     ( pwdata     ),
    .prdata     ( prdata     ),
    .pslverr    ( pslverr    ),
    .pready     ( pready     ),
    .ints       ( ints       ),
    .msip       ( msip       ),
    .mtip       ( mtip       ),
    .meip       ( meip       ),
    .core_reset ( core_reset )
);

initial begin
    clk = 1'b0;
    forever begin
        #(CLK_PERIOD/2) clk = ~clk;
    end
end

function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
        err_count++;
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
endtask

// side is {msip, mtip, meip, core_reset} after the row
task automatic add_row(input logic [1:0] op, input logic [31:0] addr, input logic [3:0] strb,
                       input logic [31:0] data, input logic [7:0] ints_val,
                       input logic [31:0] exp_rdata, input logic exp_err,
                       input logic [3:0] side);
    row_op[n_rows]    = op;
    row_addr[n_rows]  = addr;
    row_strb[n_rows]  = strb;
    row_data[n_rows]  = data;
    row_ints[n_rows]  = ints_val;
    row_rdata[n_rows] = exp_rdata;
    row_err[n_rows]   = exp_err;
    row_side[n_rows]  = side;
    n_rows++;
endtask

task automatic run_row(input int idx);
    int errs_before;
    errs_before = err_count;
    ints = row_ints[idx];
    if (row_op[idx] == OP_IDLE) begin
        psel    = 1'b0;
        penable = 1'b0;
        @(posedge clk);
        #DRIVE_DLY;
    end
    else begin
        // setup cycle
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = (row_op[idx] == OP_WRITE);
        paddr   = row_addr[idx];
        pstrb   = row_strb[idx];
        pwdata  = row_data[idx];
        @(posedge clk);
        #DRIVE_DLY;
        penable = 1'b1;
        // responses settle by mid access cycle
        #(CLK_PERIOD/2);
        check_value("pready", 32'd1, {31'd0, pready});
        check_value("pslverr", {31'd0, row_err[idx]}, {31'd0, pslverr});
        if (row_op[idx] == OP_READ) begin
            check_value("prdata", row_rdata[idx], prdata);
        end
        @(posedge clk);
        #DRIVE_DLY;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    end
    check_value("msip", {31'd0, row_side[idx][3]}, {31'd0, msip});
    check_value("mtip", {31'd0, row_side[idx][2]}, {31'd0, mtip});
    check_value("meip", {31'd0, row_side[idx][1]}, {31'd0, meip});
    check_value("core_reset", {31'd0, row_side[idx][0]}, {31'd0, core_reset});
    $display("row %0d addr %h: %0d mismatches", idx, row_addr[idx], err_count - errs_before);
endtask

task automatic build_table();
    logic [31:0] merged;
    merged = (32'hA5A5_5A5A & 32'hFF00_FF00) | (scratch_rnd & 32'h00FF_00FF);
    // intc held in reset until core_reset drops
    add_row(OP_WRITE, INTC_BASE + INTC_MSIP, 4'hf, 32'h1, 8'h0, 32'h0, 1'b0, 4'b0001);
    add_row(OP_READ,  INTC_BASE + INTC_MSIP, 4'hf, 32'h0, 8'h0, 32'h0, 1'b0, 4'b0001);
    add_row(OP_WRITE, CFG_BASE + CFG_CORE_CTRL, 4'hf, 32'h0, 8'h0, 32'h0, 1'b0, 4'b0000);
    // cfgreg
    add_row(OP_WRITE, CFG_BASE + CFG_SCRATCH, 4'hf, 32'hA5A5_5A5A, 8'h0, 32'h0, 1'b0, 4'b0000);
    add_row(OP_WRITE, CFG_BASE + CFG_SCRATCH, 4'b0101, scratch_rnd, 8'h0, 32'h0, 1'b0, 4'b0000);
    add_row(OP_READ,  CFG_BASE + CFG_SCRATCH, 4'hf, 32'h0, 8'h0, merged, 1'b0, 4'b0000);
    add_row(OP_READ,  CFG_BASE + CFG_VERSION, 4'hf, 32'h0, 8'h0, 32'h0001_0200, 1'b0, 4'b0000);
    add_row(OP_WRITE, CFG_BASE + CFG_VERSION, 4'hf, 32'h5, 8'h0, 32'h0, 1'b1, 4'b0000);
    add_row(OP_READ,  CFG_BASE + 32'h00C, 4'hf, 32'h0, 8'h0, 32'h0, 1'b1, 4'b0000);
    add_row(OP_WRITE, CFG_BASE + 32'h100, 4'hf, 32'h7, 8'h0, 32'h0, 1'b1, 4'b0000);
    // msip
    add_row(OP_WRITE, INTC_BASE + INTC_MSIP, 4'hf, 32'h1, 8'h0, 32'h0, 1'b0, 4'b1000);
    add_row(OP_READ,  INTC_BASE + INTC_MSIP, 4'hf, 32'h0, 8'h0, 32'h1, 1'b0, 4'b1000);
    add_row(OP_WRITE, INTC_BASE + INTC_MSIP, 4'hf, 32'h0, 8'h0, 32'h0, 1'b0, 4'b0000);
    // timer compare
    // mtip lags the compare by one edge
    add_row(OP_WRITE, INTC_BASE + INTC_MTIMECMP_LO, 4'hf, 32'h40, 8'h0, 32'h0, 1'b0, 4'b0000);
    add_row(OP_WRITE, INTC_BASE + INTC_MTIMECMP_HI, 4'hf, 32'h0, 8'h0, 32'h0, 1'b0, 4'b0000);
    add_row(OP_IDLE,  32'h0, 4'h0, 32'h0, 8'h0, 32'h0, 1'b0, 4'b0000);
    add_row(OP_WRITE, INTC_BASE + INTC_MTIME_LO, 4'hf, 32'h100, 8'h0, 32'h0, 1'b0, 4'b0000);
    add_row(OP_IDLE,  32'h0, 4'h0, 32'h0, 8'h0, 32'h0, 1'b0, 4'b0100);
    add_row(OP_WRITE, INTC_BASE + INTC_MTIMECMP_HI, 4'hf, 32'h1, 8'h0, 32'h0, 1'b0, 4'b0100);
    add_row(OP_READ,  INTC_BASE + INTC_MTIMECMP_HI, 4'hf, 32'h0, 8'h0, 32'h1, 1'b0, 4'b0000);
    // six edges after the mtime write, one prescaler period has passed
    add_row(OP_READ,  INTC_BASE + INTC_MTIME_LO, 4'hf, 32'h0, 8'h0, 32'h101, 1'b0, 4'b0000);
    // external interrupts
    add_row(OP_IDLE,  32'h0, 4'h0, 32'h0, 8'h08, 32'h0, 1'b0, 4'b0000);
    add_row(OP_READ,  INTC_BASE + INTC_EIP, 4'hf, 32'h0, 8'h0, 32'h08, 1'b0, 4'b0000);
    add_row(OP_WRITE, INTC_BASE + INTC_EIE, 4'hf, 32'h08, 8'h0, 32'h0, 1'b0, 4'b0000);
    add_row(OP_READ,  INTC_BASE + INTC_EIE, 4'hf, 32'h0, 8'h0, 32'h08, 1'b0, 4'b0010);
    add_row(OP_WRITE, INTC_BASE + INTC_EIC, 4'hf, 32'h08, 8'h0, 32'h0, 1'b0, 4'b0010);
    add_row(OP_READ,  INTC_BASE + INTC_EIP, 4'hf, 32'h0, 8'h0, 32'h0, 1'b0, 4'b0000);
    add_row(OP_WRITE, INTC_BASE + INTC_EIP, 4'hf, 32'hff, 8'h0, 32'h0, 1'b1, 4'b0000);
    // same offset on both sides of bit 27
    add_row(OP_WRITE, CFG_BASE + 32'h004, 4'hf, 32'h1234_5678, 8'h0, 32'h0, 1'b0, 4'b0000);
    add_row(OP_READ,  CFG_BASE + 32'h004, 4'hf, 32'h0, 8'h0, 32'h1234_5678, 1'b0, 4'b0000);
    add_row(OP_READ,  INTC_BASE + 32'h004, 4'hf, 32'h0, 8'h0, 32'h0, 1'b1, 4'b0000);
    add_row(OP_WRITE, INTC_BASE + 32'h004, 4'hf, 32'h9, 8'h0, 32'h0, 1'b1, 4'b0000);
endtask

initial begin
    wait (table_ready === 1'b1);
    #(n_rows * 4 * CLK_PERIOD * 2);
    $display("watchdog expired before all rows completed");
    $display("Simulation finished: FAIL");
    $finish;
end

initial begin
    table_ready = 1'b0;
    reset       = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pstrb       = '0;
    pwdata      = '0;
    ints        = '0;
    n_rows      = 0;
    err_count   = 0;
    check_count = 0;
    lcg_state   = 32'hde86;
    lcg_state   = lcg_next(lcg_state);
    scratch_rnd = lcg_state;
    build_table();
    table_ready = 1'b1;

    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    reset = 1'b0;

    for (int i = 0; i < n_rows; i++) begin
        run_row(i);
    end

    $display("rows: %0d, checks: %0d, mismatches: %0d", n_rows, check_count, err_count);
    if (err_count == 0) begin
        $display("Simulation finished: PASS");
    end
    else begin
        $display("Simulation finished: FAIL");
    end
    $finish;
end

endmodule

`default_nettype wire

/* hw/periph_subsys.sv */
`timescale 1ns/1ns
`default_nettype none

module periph_subsys (
    input  logic                               clk,
    input  logic                               reset,

    // peripheral apb
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [periph_pkg::ADDR_W-1:0]      paddr,
    input  logic [periph_pkg::STRB_W-1:0]      pstrb,
    input  logic [periph_pkg::DATA_W-1:0]      pwdata,
    output logic [periph_pkg::DATA_W-1:0]      prdata,
    output logic                               pslverr,
    output logic                               pready,

    input  logic [periph_pkg::NUM_EXT_IRQ-1:0] ints,
    output logic                               msip,
    output logic                               mtip,
    output logic                               meip,
    output logic                               core_reset
);

import periph_pkg::*;

logic              sel_intc;
logic              intc_reset;

logic              intc_psel;
logic              intc_penable;
logic [DATA_W-1:0] intc_prdata;
logic              intc_pslverr;
logic              intc_pready;

logic              cfgreg_psel;
logic              cfgreg_penable;
logic [DATA_W-1:0] cfgreg_prdata;
logic              cfgreg_pslverr;
logic              cfgreg_pready;

assign sel_intc       = paddr[SEL_BIT];

assign intc_psel      = sel_intc && psel;
assign intc_penable   = sel_intc && penable;
assign cfgreg_psel    = !sel_intc && psel;
assign cfgreg_penable = !sel_intc && penable;

assign prdata         = sel_intc ? intc_prdata  : cfgreg_prdata;
assign pslverr        = sel_intc ? intc_pslverr : cfgreg_pslverr;
assign pready         = sel_intc ? intc_pready  : cfgreg_pready;

// interrupt controller sits in the core reset domain
assign intc_reset     = reset || core_reset;

cfgreg u_cfgreg (
    .clk        ( clk            ),
    .reset      ( reset          ),
    .psel       ( cfgreg_psel    ),
    .penable    ( cfgreg_penable ),
    .pwrite     ( pwrite         ),
    .paddr      ( paddr          ),
    .pstrb      ( pstrb          ),
    .pwdata     ( pwdata         ),
    .prdata     ( cfgreg_prdata  ),
    .pslverr    ( cfgreg_pslverr ),
    .pready     ( cfgreg_pready  ),
    .core_reset ( core_reset     )
);

intc u_intc (
    .clk     ( clk          ),
    .reset   ( intc_reset   ),
    .psel    ( intc_psel    ),
    .penable ( intc_penable ),
    .pwrite  ( pwrite       ),
    .paddr   ( paddr        ),
    .pstrb   ( pstrb        ),
    .pwdata  ( pwdata       ),
    .prdata  ( intc_prdata  ),
    .pslverr ( intc_pslverr ),
    .pready  ( intc_pready  ),
    .ints    ( ints         ),
    .msip    ( msip         ),
    .mtip    ( mtip         ),
    .meip    ( meip         )
);

endmodule

`default_nettype wire

/* hw/cfgreg.sv */
`timescale 1ns/1ns
`default_nettype none

module cfgreg (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [periph_pkg::ADDR_W-1:0] paddr,
    input  logic [periph_pkg::STRB_W-1:0] pstrb,
    input  logic [periph_pkg::DATA_W-1:0] pwdata,
    output logic [periph_pkg::DATA_W-1:0] prdata,
    output logic                          pslverr,
    output logic                          pready,

    output logic                          core_reset
);

import periph_pkg::*;

cfg_reg_e          ofs;
logic              access;
logic              wr_acc;
logic              unmapped;
logic              read_only;
logic              core_hold;
logic [DATA_W-1:0] scratch;

assign ofs    = cfg_reg_e'(paddr[OFS_W-1:0]);
assign access = psel && penable;
assign wr_acc = access && pwrite;

always_comb begin
    prdata    = '0;
    unmapped  = 1'b0;
    read_only = 1'b0;
    case (ofs)
        CFG_CORE_CTRL: prdata = {{(DATA_W-1){1'b0}}, core_hold};
        CFG_SCRATCH:   prdata = scratch;
        CFG_VERSION: begin
            prdata    = CFG_VERSION_VAL;
            read_only = 1'b1;
        end
        default:       unmapped = 1'b1;
    endcase
end

assign pslverr = access && (unmapped || (read_only && pwrite));
assign pready  = 1'b1;

// core held in reset until software releases it
always_ff @(posedge clk) begin
    if (reset) begin
        core_hold <= CORE_HOLD_RESET;
    end
    else if (wr_acc && ofs == CFG_CORE_CTRL) begin
        core_hold <= pwdata[0];
    end
end

always_ff @(posedge clk) begin
    if (wr_acc && ofs == CFG_SCRATCH) begin
        scratch <= strb_merge(scratch, pwdata, pstrb);
    end
end

assign core_reset = core_hold;

endmodule

`default_nettype wire

/* hw/intc.sv */
`timescale 1ns/1ns
`default_nettype none

module intc (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [periph_pkg::ADDR_W-1:0]      paddr,
    input  logic [periph_pkg::STRB_W-1:0]      pstrb,
    input  logic [periph_pkg::DATA_W-1:0]      pwdata,
    output logic [periph_pkg::DATA_W-1:0]      prdata,
    output logic                               pslverr,
    output logic                               pready,

    input  logic [periph_pkg::NUM_EXT_IRQ-1:0] ints,
    output logic                               msip,
    output logic                               mtip,
    output logic                               meip
);

import periph_pkg::*;

intc_reg_e              ofs;
logic                   live;
logic                   access;
logic                   wr_acc;
logic                   unmapped;
logic                   read_only;
logic [DATA_W-1:0]      rdata;

logic                   msip_wr;
logic                   mtime_wr_lo;
logic                   mtime_wr_hi;
logic                   cmp_wr_lo;
logic                   cmp_wr_hi;
logic                   eie_wr;
logic                   eic_wr;

logic [MTIME_W-1:0]     mtime;
logic [MTIME_W-1:0]     mtimecmp;
logic [NUM_EXT_IRQ-1:0] pending;
logic [NUM_EXT_IRQ-1:0] enable;

// goes high one cycle after the block leaves reset
always_ff @(posedge clk) begin
    if (reset) begin
        live <= 1'b0;
    end
    else begin
        live <= 1'b1;
    end
end

assign ofs    = intc_reg_e'(paddr[OFS_W-1:0]);
assign access = psel && penable && live;
assign wr_acc = access && pwrite;

always_comb begin
    rdata       = '0;
    unmapped    = 1'b0;
    read_only   = 1'b0;
    msip_wr     = 1'b0;
    mtime_wr_lo = 1'b0;
    mtime_wr_hi = 1'b0;
    cmp_wr_lo   = 1'b0;
    cmp_wr_hi   = 1'b0;
    eie_wr      = 1'b0;
    eic_wr      = 1'b0;
    case (ofs)
        INTC_MSIP: begin
            rdata   = {{(DATA_W-1){1'b0}}, msip};
            msip_wr = wr_acc;
        end
        INTC_MTIMECMP_LO: begin
            rdata     = mtimecmp[DATA_W-1:0];
            cmp_wr_lo = wr_acc;
        end
        INTC_MTIMECMP_HI: begin
            rdata     = mtimecmp[MTIME_W-1:DATA_W];
            cmp_wr_hi = wr_acc;
        end
        INTC_MTIME_LO: begin
            rdata       = mtime[DATA_W-1:0];
            mtime_wr_lo = wr_acc;
        end
        INTC_MTIME_HI: begin
            rdata       = mtime[MTIME_W-1:DATA_W];
            mtime_wr_hi = wr_acc;
        end
        INTC_EIP: begin
            rdata     = {{(DATA_W-NUM_EXT_IRQ){1'b0}}, pending};
            read_only = 1'b1;
        end
        INTC_EIE: begin
            rdata  = {{(DATA_W-NUM_EXT_IRQ){1'b0}}, enable};
            eie_wr = wr_acc;
        end
        // write-one-to-clear, reads as zero
        INTC_EIC: eic_wr = wr_acc;
        default:  unmapped = 1'b1;
    endcase
end

assign prdata  = live ? rdata : '0;
assign pslverr = access && (unmapped || (read_only && pwrite));
assign pready  = 1'b1;

always_ff @(posedge clk) begin
    if (reset) begin
        msip <= 1'b0;
    end
    else if (msip_wr) begin
        msip <= pwdata[0];
    end
end

mtimer u_mtimer (
    .clk         ( clk         ),
    .reset       ( reset       ),
    .mtime_wr_lo ( mtime_wr_lo ),
    .mtime_wr_hi ( mtime_wr_hi ),
    .cmp_wr_lo   ( cmp_wr_lo   ),
    .cmp_wr_hi   ( cmp_wr_hi   ),
    .wr_strb     ( pstrb       ),
    .wr_data     ( pwdata      ),
    .mtime       ( mtime       ),
    .mtimecmp    ( mtimecmp    ),
    .mtip        ( mtip        )
);

ext_irq_ctrl u_ext_irq_ctrl (
    .clk     ( clk     ),
    .reset   ( reset   ),
    .ints    ( ints    ),
    .eie_wr  ( eie_wr  ),
    .eic_wr  ( eic_wr  ),
    .wr_data ( pwdata  ),
    .pending ( pending ),
    .enable  ( enable  ),
    .meip    ( meip    )
);

endmodule

`default_nettype wire

/* hw/ext_irq_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module ext_irq_ctrl (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [periph_pkg::NUM_EXT_IRQ-1:0] ints,
    input  logic                               eie_wr,
    input  logic                               eic_wr,
    input  logic [periph_pkg::DATA_W-1:0]      wr_data,
    output logic [periph_pkg::NUM_EXT_IRQ-1:0] pending,
    output logic [periph_pkg::NUM_EXT_IRQ-1:0] enable,
    output logic                               meip
);

import periph_pkg::*;

logic [NUM_EXT_IRQ-1:0] clr_mask;

assign clr_mask = eic_wr ? wr_data[NUM_EXT_IRQ-1:0] : '0;

// new lines win over a clear on the same edge
always_ff @(posedge clk) begin
    if (reset) begin
        pending <= '0;
    end
    else begin
        pending <= (pending & ~clr_mask) | ints;
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        enable <= '0;
    end
    else if (eie_wr) begin
        enable <= wr_data[NUM_EXT_IRQ-1:0];
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        meip <= 1'b0;
    end
    else begin
        meip <= |(pending & enable);
    end
end

endmodule

`default_nettype wire

/* hw/mtimer.sv */
`timescale 1ns/1ns
`default_nettype none

module mtimer (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           mtime_wr_lo,
    input  logic                           mtime_wr_hi,
    input  logic                           cmp_wr_lo,
    input  logic                           cmp_wr_hi,
    input  logic [periph_pkg::STRB_W-1:0]  wr_strb,
    input  logic [periph_pkg::DATA_W-1:0]  wr_data,
    output logic [periph_pkg::MTIME_W-1:0] mtime,
    output logic [periph_pkg::MTIME_W-1:0] mtimecmp,
    output logic                           mtip
);

import periph_pkg::*;

logic [PRESC_W-1:0] presc;
logic               tick;

assign tick = (presc == PRESC_W'(MTIME_DIV - 1));

// a write to either word restarts the prescaler
always_ff @(posedge clk) begin
    if (reset) begin
        mtime <= '0;
        presc <= '0;
    end
    else if (mtime_wr_lo || mtime_wr_hi) begin
        presc <= '0;
        if (mtime_wr_lo) begin
            mtime[DATA_W-1:0] <= strb_merge(mtime[DATA_W-1:0], wr_data, wr_strb);
        end
        if (mtime_wr_hi) begin
            mtime[MTIME_W-1:DATA_W] <= strb_merge(mtime[MTIME_W-1:DATA_W], wr_data, wr_strb);
        end
    end
    else if (tick) begin
        mtime <= mtime + 1'b1;
        presc <= '0;
    end
    else begin
        presc <= presc + 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        mtimecmp <= '1;
    end
    else begin
        if (cmp_wr_lo) begin
            mtimecmp[DATA_W-1:0] <= strb_merge(mtimecmp[DATA_W-1:0], wr_data, wr_strb);
        end
        if (cmp_wr_hi) begin
            mtimecmp[MTIME_W-1:DATA_W] <= strb_merge(mtimecmp[MTIME_W-1:DATA_W], wr_data, wr_strb);
        end
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        mtip <= 1'b0;
    end
    else begin
        mtip <= (mtime >= mtimecmp);
    end
end

endmodule

`default_nettype wire

/* hw/periph_pkg.sv */
`default_nettype none

package periph_pkg;

// apb bus
localparam int ADDR_W  = 32;
localparam int DATA_W  = 32;
localparam int STRB_W  = 4;
localparam int BYTE_W  = 8;

// address map
localparam int SEL_BIT = 27;
localparam int OFS_W   = 12;

// interrupt controller
localparam int NUM_EXT_IRQ = 8;
localparam int MTIME_W     = 64;
localparam int MTIME_DIV   = 4;
localparam int PRESC_W     = $clog2(MTIME_DIV);

// config block constants
localparam logic [DATA_W-1:0] CFG_VERSION_VAL = 32'h0001_0200;
localparam logic              CORE_HOLD_RESET = 1'b1;

typedef enum logic [OFS_W-1:0] {
    CFG_CORE_CTRL = 12'h000,
    CFG_SCRATCH   = 12'h004,
    CFG_VERSION   = 12'h008
} cfg_reg_e;

typedef enum logic [OFS_W-1:0] {
    INTC_MSIP        = 12'h000,
    INTC_MTIMECMP_LO = 12'h010,
    INTC_MTIMECMP_HI = 12'h014,
    INTC_MTIME_LO    = 12'h018,
    INTC_MTIME_HI    = 12'h01C,
    INTC_EIP         = 12'h020,
    INTC_EIE         = 12'h024,
    INTC_EIC         = 12'h028
} intc_reg_e;

// replace the bytes of old_word selected by strb
function automatic logic [DATA_W-1:0] strb_merge(
    input logic [DATA_W-1:0] old_word,
    input logic [DATA_W-1:0] new_word,
    input logic [STRB_W-1:0] strb
);
    logic [DATA_W-1:0] res;
    int                i;
    res = old_word;
    for (i = 0; i < STRB_W; i++) begin
        if (strb[i]) begin
            res[BYTE_W*i +: BYTE_W] = new_word[BYTE_W*i +: BYTE_W];
        end
    end
    return res;
endfunction

endpackage

`default_nettype wire
